// File: rtl/vga_filter_params.svh
`ifndef VGA_FILTER_PARAMS_SVH
`define VGA_FILTER_PARAMS_SVH

`define H_VISIBLE    640
`define H_SYNC_START 656
`define H_SYNC_END   752
`define H_TOTAL      800

`define V_VISIBLE    480
`define V_SYNC_START 490
`define V_SYNC_END   492
`define V_TOTAL      525

`define CNT_W        10

`define WIN_W        160
`define WIN_H        114
`define WIN_X_LEFT   0
`define WIN_X_RIGHT  479
`define WIN_Y_TOP    0
`define WIN_Y_BOTTOM 365

`define IMG_DEPTH    18240
`define ADDR_W       15
`define WORD_W       96
`define SAMPLE_W     8
`define COLOR_W      4
`define BLUR_DIV     18
`define SEL_W        3

// image word, gray samples from the top: centre, left, right, up, down,
// left-up, left-down, right-up, right-down
`define GRAY_MSB     95
`define GRAY_LSB     24
`define GRAY_COUNT   9
`define BLUE_LSB     16
`define GREEN_LSB    8
`define RED_LSB      0

`endif

// File: rtl/vga_filter_pkg.sv
`include "vga_filter_params.svh"

package vga_filter_pkg;

  // top nibble of a byte sample
  function automatic logic [`COLOR_W-1:0] to_nibble(input logic [`SAMPLE_W-1:0] sample);
    return sample[`SAMPLE_W-1 -: `COLOR_W];
  endfunction

  // box blur over the 3x3 gray neighbourhood
  function automatic logic [`COLOR_W-1:0] blur_level(
    input logic [`GRAY_MSB-`GRAY_LSB:0] grays
  );
    logic [`SAMPLE_W+3:0] sum;
    logic [`SAMPLE_W+3:0] quot;
    int                   i;
    sum = '0;
    for (i = 0; i < `GRAY_COUNT; i++) begin
      sum = sum + grays[i*`SAMPLE_W +: `SAMPLE_W];
    end
    quot = sum / `BLUR_DIV; // at most 127, so the low byte holds it
    return quot[`SAMPLE_W-1 -: `COLOR_W];
  endfunction

  // bit 0 of the window index picks the right column
  function automatic logic [`CNT_W-1:0] window_x0(input logic [1:0] win);
    return win[0] ? `CNT_W'(`WIN_X_RIGHT) : `CNT_W'(`WIN_X_LEFT);
  endfunction

  // bit 1 picks the bottom row
  function automatic logic [`CNT_W-1:0] window_y0(input logic [1:0] win);
    return win[1] ? `CNT_W'(`WIN_Y_BOTTOM) : `CNT_W'(`WIN_Y_TOP);
  endfunction

endpackage

// File: rtl/scan_if.sv
`timescale 1ns/100ps
`include "vga_filter_params.svh"

interface scan_if;
  logic              pixel_en; // first clk of each two-clk pixel
  logic [`CNT_W-1:0] hcount;
  logic [`CNT_W-1:0] vcount;
  logic              visible;

  modport source (
    output pixel_en, hcount, vcount, visible
  );

  modport sink (
    input pixel_en, hcount, vcount, visible
  );

endinterface

// File: rtl/vga_timing.sv
`timescale 1ns/100ps
`include "vga_filter_params.svh"

module vga_timing (
  input  logic   clk,
  input  logic   reset,
  scan_if.source scan,
  output logic   hsync_raw_o,
  output logic   vsync_raw_o
);

  logic              pixel_en;
  logic [`CNT_W-1:0] hcount;
  logic [`CNT_W-1:0] vcount;
  logic              line_end;
  logic              frame_end;

  assign line_end  = hcount == `CNT_W'(`H_TOTAL - 1);
  assign frame_end = vcount == `CNT_W'(`V_TOTAL - 1);

  // pixel rate is half of clk
  always_ff @(posedge clk) begin
    if (reset) begin
      pixel_en <= 1'b1; // first clk after reset is a pixel cycle
    end else begin
      pixel_en <= ~pixel_en;
    end
  end

  // position moves on after the second clk of each pixel
  always_ff @(posedge clk) begin
    if (reset) begin
      hcount <= '0;
      vcount <= '0;
    end else if (!pixel_en) begin
      if (line_end) begin
        hcount <= '0;
        if (frame_end) begin
          vcount <= '0;
        end else begin
          vcount <= vcount + 1'b1;
        end
      end else begin
        hcount <= hcount + 1'b1;
      end
    end
  end

  assign scan.pixel_en = pixel_en;
  assign scan.hcount   = hcount;
  assign scan.vcount   = vcount;
  assign scan.visible  = (hcount < `H_VISIBLE) && (vcount < `V_VISIBLE);

  // active low
  assign hsync_raw_o = !((hcount >= `H_SYNC_START) && (hcount < `H_SYNC_END));
  assign vsync_raw_o = !((vcount >= `V_SYNC_START) && (vcount < `V_SYNC_END));

endmodule

// File: rtl/window_addr.sv
`timescale 1ns/100ps
`include "vga_filter_params.svh"

module window_addr (
  input  logic               clk,
  input  logic               reset,
  scan_if.sink               scan,
  input  logic [`SEL_W-1:0]  sel_i,
  output logic [`ADDR_W-1:0] rd_addr_o,
  output logic               in_window_o,
  output logic               blur_mode_o
);

  logic [`SEL_W-1:0]  sel_q;
  logic [`SEL_W-1:0]  sel_cur;
  logic               frame_start;
  logic [`CNT_W-1:0]  x0;
  logic [`CNT_W-1:0]  y0;
  logic               hit;
  logic               at_origin;
  logic               hit_q;
  logic               blur_q;

  assign frame_start = scan.pixel_en && (scan.hcount == '0) && (scan.vcount == '0);

  // the new selection already applies to pixel (0,0)
  assign sel_cur = frame_start ? sel_i : sel_q;

  assign x0 = vga_filter_pkg::window_x0(sel_cur[1:0]);
  assign y0 = vga_filter_pkg::window_y0(sel_cur[1:0]);

  assign hit = (scan.hcount >= x0) && (scan.hcount < x0 + `WIN_W) &&
               (scan.vcount >= y0) && (scan.vcount < y0 + `WIN_H);

  assign at_origin = (scan.hcount == x0) && (scan.vcount == y0);

  always_ff @(posedge clk) begin
    if (reset) begin
      sel_q <= '0;
    end else if (frame_start) begin
      sel_q <= sel_i;
    end
  end

  // row-major address, restarts at the window origin
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_addr_o <= '0;
    end else if (scan.pixel_en && hit) begin
      if (at_origin) begin
        rd_addr_o <= '0;
      end else begin
        rd_addr_o <= rd_addr_o + 1'b1;
      end
    end
  end

  // two stages so the flags line up with the memory word
  always_ff @(posedge clk) begin
    if (reset) begin
      hit_q       <= 1'b0;
      in_window_o <= 1'b0;
      blur_q      <= 1'b0;
      blur_mode_o <= 1'b0;
    end else begin
      hit_q       <= hit;
      in_window_o <= hit_q;
      blur_q      <= sel_cur[2];
      blur_mode_o <= blur_q;
    end
  end

endmodule

// File: rtl/image_memory.sv
`timescale 1ns/100ps
`include "vga_filter_params.svh"

module image_memory (
  input  logic               clk,
  input  logic               we_i,
  input  logic [`ADDR_W-1:0] wr_addr_i,
  input  logic [`WORD_W-1:0] wr_data_i,
  input  logic [`ADDR_W-1:0] rd_addr_i,
  output logic [`WORD_W-1:0] rd_data_o
);

  logic [`WORD_W-1:0] mem [`IMG_DEPTH];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  always_ff @(posedge clk) begin
    rd_data_o <= mem[rd_addr_i]; // one clk read latency
  end

endmodule

// File: rtl/pixel_filter.sv
`timescale 1ns/100ps
`include "vga_filter_params.svh"

module pixel_filter (
  input  logic                clk,
  input  logic                reset,
  scan_if.sink                scan,
  input  logic [`WORD_W-1:0]  word_i,
  input  logic                in_window_i,
  input  logic                blur_mode_i,
  input  logic                hsync_raw_i,
  input  logic                vsync_raw_i,
  output logic                hsync_o,
  output logic                vsync_o,
  output logic [`COLOR_W-1:0] red_o,
  output logic [`COLOR_W-1:0] green_o,
  output logic [`COLOR_W-1:0] blue_o
);

  logic [1:0]          hs_d;
  logic [1:0]          vs_d;
  logic [1:0]          vis_d;
  logic                show;
  logic [`COLOR_W-1:0] blur_lvl;
  logic [`COLOR_W-1:0] red_c;
  logic [`COLOR_W-1:0] green_c;
  logic [`COLOR_W-1:0] blue_c;

  assign show     = vis_d[1] && in_window_i;
  assign blur_lvl = vga_filter_pkg::blur_level(word_i[`GRAY_MSB:`GRAY_LSB]);

  always_comb begin
    if (!show) begin
      red_c   = '0;
      green_c = '0;
      blue_c  = '0;
    end else if (blur_mode_i) begin
      red_c   = blur_lvl; // gray on all channels
      green_c = blur_lvl;
      blue_c  = blur_lvl;
    end else begin
      red_c   = vga_filter_pkg::to_nibble(word_i[`RED_LSB +: `SAMPLE_W]);
      green_c = vga_filter_pkg::to_nibble(word_i[`GREEN_LSB +: `SAMPLE_W]);
      blue_c  = vga_filter_pkg::to_nibble(word_i[`BLUE_LSB +: `SAMPLE_W]);
    end
  end

  // syncs and blanking ride two stages to meet the memory word
  always_ff @(posedge clk) begin
    if (reset) begin
      hs_d    <= 2'b11;
      vs_d    <= 2'b11;
      vis_d   <= 2'b00;
      hsync_o <= 1'b1;
      vsync_o <= 1'b1;
      red_o   <= '0;
      green_o <= '0;
      blue_o  <= '0;
    end else begin
      hs_d    <= {hs_d[0], hsync_raw_i};
      vs_d    <= {vs_d[0], vsync_raw_i};
      vis_d   <= {vis_d[0], scan.visible};
      hsync_o <= hs_d[1];
      vsync_o <= vs_d[1];
      red_o   <= red_c;
      green_o <= green_c;
      blue_o  <= blue_c;
    end
  end

endmodule

// File: rtl/vga_filter_top.sv
`timescale 1ns/100ps
`include "vga_filter_params.svh"

module vga_filter_top (
  input  logic                clk,
  input  logic                reset,
  input  logic [`SEL_W-1:0]   sel_i,
  input  logic                image_we_i,
  input  logic [`ADDR_W-1:0]  image_addr_i,
  input  logic [`WORD_W-1:0]  image_data_i,
  output logic                hsync_o,
  output logic                vsync_o,
  output logic [`COLOR_W-1:0] red_o,
  output logic [`COLOR_W-1:0] green_o,
  output logic [`COLOR_W-1:0] blue_o
);

  logic               hsync_raw;
  logic               vsync_raw;
  logic [`ADDR_W-1:0] rd_addr;
  logic [`WORD_W-1:0] rd_word;
  logic               in_window;
  logic               blur_mode;

  scan_if scan_bus ();

  vga_timing vga_timing_i (
    .clk         (clk),
    .reset       (reset),
    .scan        (scan_bus.source),
    .hsync_raw_o (hsync_raw),
    .vsync_raw_o (vsync_raw)
  );

  window_addr window_addr_i (
    .clk         (clk),
    .reset       (reset),
    .scan        (scan_bus.sink),
    .sel_i       (sel_i),
    .rd_addr_o   (rd_addr),
    .in_window_o (in_window),
    .blur_mode_o (blur_mode)
  );

  image_memory image_memory_i (
    .clk       (clk),
    .we_i      (image_we_i),
    .wr_addr_i (image_addr_i),
    .wr_data_i (image_data_i),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_word)
  );

  pixel_filter pixel_filter_i (
    .clk         (clk),
    .reset       (reset),
    .scan        (scan_bus.sink),
    .word_i      (rd_word),
    .in_window_i (in_window),
    .blur_mode_i (blur_mode),
    .hsync_raw_i (hsync_raw),
    .vsync_raw_i (vsync_raw),
    .hsync_o     (hsync_o),
    .vsync_o     (vsync_o),
    .red_o       (red_o),
    .green_o     (green_o),
    .blue_o      (blue_o)
  );

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
  parameter int HALF_PERIOD  = 5,
  parameter int RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// File: tests/tb_vga_filter_tasks.svh
// reference copy of what was written into the image store
logic [`WORD_W-1:0] image_copy [`IMG_DEPTH];

task automatic stop_on_error(input string what);
  $display("%s", what);
  $display("TEST FAILED");
  $fatal(1, "run stopped at the first error");
endtask

task automatic compare_sync(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    stop_on_error($sformatf("CHECK FAILED %s: expected %h, got %h (%s, h %0d v %0d)",
                            name, exp, act, phase, pix_h, pix_v));
  end
endtask

task automatic compare_channel(input string name, input logic [`COLOR_W-1:0] exp,
                               input logic [`COLOR_W-1:0] act);
  if (act !== exp) begin
    stop_on_error($sformatf("CHECK FAILED %s: expected %h, got %h (%s, h %0d v %0d)",
                            name, exp, act, phase, pix_h, pix_v));
  end
endtask

task automatic load_image();
  logic [`WORD_W-1:0] word;
  int                 a;
  for (a = 0; a < `IMG_DEPTH; a++) begin
    word = {$urandom(), $urandom(), $urandom()};
    image_copy[a] = word;
    @(posedge clk);
    image_we_i   <= 1'b1;
    image_addr_i <= `ADDR_W'(a);
    image_data_i <= word;
  end
  @(posedge clk);
  image_we_i <= 1'b0;
endtask

// mean of the nine gray bytes, scaled by 1/18, top nibble of the low byte
function automatic logic [`COLOR_W-1:0] blur_expect(input logic [`WORD_W-1:0] word);
  logic [15:0] sum;
  logic [15:0] quot;
  int          k;
  sum = '0;
  for (k = 0; k < 9; k++) begin
    sum = sum + word[`GRAY_LSB + 8*k +: 8];
  end
  quot = sum / 18;
  return quot[7:4];
endfunction

task automatic check_pixel(input int h, input int v, input logic [`SEL_W-1:0] sel,
                           input bit syncs_only);
  logic               exp_hs;
  logic               exp_vs;
  int                 x0;
  int                 y0;
  bit                 in_win;
  logic [`WORD_W-1:0] word;
  logic [`COLOR_W-1:0] exp_r;
  logic [`COLOR_W-1:0] exp_g;
  logic [`COLOR_W-1:0] exp_b;
  exp_hs = !(h >= 656 && h <= 751);
  exp_vs = !(v >= 490 && v <= 491);
  compare_sync("hsync_o", exp_hs, hsync_o);
  compare_sync("vsync_o", exp_vs, vsync_o);
  if (!syncs_only) begin
    x0 = sel[0] ? 479 : 0;
    y0 = sel[1] ? 365 : 0;
    in_win = (h < 640) && (v < 480) && (h >= x0) && (h < x0 + 160) &&
             (v >= y0) && (v < y0 + 114);
    exp_r = '0;
    exp_g = '0;
    exp_b = '0;
    if (in_win) begin
      word = image_copy[(v - y0) * 160 + (h - x0)];
      if (sel[2]) begin
        exp_r = blur_expect(word);
        exp_g = exp_r;
        exp_b = exp_r;
      end else begin
        exp_r = word[7:4];
        exp_g = word[15:12];
        exp_b = word[23:20];
      end
    end
    compare_channel("red_o", exp_r, red_o);
    compare_channel("green_o", exp_g, green_o);
    compare_channel("blue_o", exp_b, blue_o);
  end
endtask

// pixel n of a frame is checked in both clk of its output hold
task automatic check_frame(input logic [`SEL_W-1:0] sel, input logic [`SEL_W-1:0] next_sel,
                           input bit syncs_only);
  int start;
  int n;
  start = OUT_DELAY;
  while (start < t_cnt) begin
    start = start + FRAME_CYCLES;
  end
  while (t_cnt != start) begin
    @(negedge clk);
  end
  for (n = 0; n < FRAME_PIXELS; n++) begin
    pix_h = n % `H_TOTAL;
    pix_v = n / `H_TOTAL;
    check_pixel(pix_h, pix_v, sel, syncs_only);
    @(negedge clk);
    check_pixel(pix_h, pix_v, sel, syncs_only);
    if (n == `V_VISIBLE * `H_TOTAL) begin
      @(posedge clk);
      sel_i <= next_sel; // latched at the next frame start
    end
    @(negedge clk);
  end
endtask

// File: tests/tb_vga_filter.sv
`timescale 1ns/100ps
`include "vga_filter_params.svh"

module tb_vga_filter;

  localparam int FRAME_PIXELS = `H_TOTAL * `V_TOTAL;
  localparam int FRAME_CYCLES = 2 * FRAME_PIXELS;    // two clk per pixel
  localparam int OUT_DELAY    = 3;                   // sample period of pixel 0, frame 0
  localparam int TEST_FRAMES  = 5;
  localparam int CYCLE_LIMIT  = TEST_FRAMES * FRAME_CYCLES + `IMG_DEPTH + 1000;

  logic                clk;
  logic                reset;
  logic [`SEL_W-1:0]   sel_i;
  logic                image_we_i;
  logic [`ADDR_W-1:0]  image_addr_i;
  logic [`WORD_W-1:0]  image_data_i;
  logic                hsync_o;
  logic                vsync_o;
  logic [`COLOR_W-1:0] red_o;
  logic [`COLOR_W-1:0] green_o;
  logic [`COLOR_W-1:0] blue_o;

  int    t_cnt       = 0; // clk periods since reset fell
  int    cycle_total = 0;
  int    pix_h       = 0;
  int    pix_v       = 0;
  string phase       = "start";

  tb_clock tb_clock_i (
    .clk_o   (clk),
    .reset_o (reset)
  );

  vga_filter_top vga_filter_top_i (
    .clk          (clk),
    .reset        (reset),
    .sel_i        (sel_i),
    .image_we_i   (image_we_i),
    .image_addr_i (image_addr_i),
    .image_data_i (image_data_i),
    .hsync_o      (hsync_o),
    .vsync_o      (vsync_o),
    .red_o        (red_o),
    .green_o      (green_o),
    .blue_o       (blue_o)
  );

  `include "tb_vga_filter_tasks.svh"

  always @(posedge clk) begin
    if (reset) begin
      t_cnt <= 0; // the first clk after reset is period 0
    end else begin
      t_cnt <= t_cnt + 1;
    end
  end

  always @(posedge clk) begin
    cycle_total <= cycle_total + 1;
    if (cycle_total >= CYCLE_LIMIT) begin
      stop_on_error($sformatf("timeout, run did not finish within %0d cycles", CYCLE_LIMIT));
    end
  end

  task automatic check_reset_outputs();
    compare_sync("hsync_o", 1'b1, hsync_o);
    compare_sync("vsync_o", 1'b1, vsync_o);
    compare_channel("red_o", '0, red_o);
    compare_channel("green_o", '0, green_o);
    compare_channel("blue_o", '0, blue_o);
  endtask

  task automatic reset_state();
    phase = "reset_state";
    @(posedge clk);
    @(negedge clk);
    while (reset) begin
      check_reset_outputs();
      @(negedge clk);
    end
    check_reset_outputs(); // first clk after reset
  endtask

  task automatic sync_timing(input logic [`SEL_W-1:0] next_sel);
    phase = "sync_timing";
    check_frame('0, next_sel, 1'b1);
  endtask

  task automatic color_window(input logic [`SEL_W-1:0] next_sel);
    phase = "color_window";
    check_frame(3'b011, next_sel, 1'b0);
  endtask

  task automatic blur_window(input logic [`SEL_W-1:0] next_sel);
    phase = "blur_window";
    check_frame(3'b100, next_sel, 1'b0);
  endtask

  task automatic window_select();
    phase = "window_select";
    check_frame(3'b001, 3'b110, 1'b0);
    check_frame(3'b110, 3'b110, 1'b0);
  endtask

  initial begin
    void'($urandom(32'h3b45));
    sel_i        = '0;
    image_we_i   = 1'b0;
    image_addr_i = '0;
    image_data_i = '0;
    reset_state();
    fork
      load_image(); // image lands well before frame 1
      sync_timing(3'b011);
    join
    color_window(3'b100);
    blur_window(3'b001);
    window_select();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+rtl
+incdir+tests
rtl/vga_filter_pkg.sv
rtl/scan_if.sv
rtl/vga_timing.sv
rtl/window_addr.sv
rtl/image_memory.sv
rtl/pixel_filter.sv
rtl/vga_filter_top.sv
tests/tb_clock.sv
tests/tb_vga_filter.sv

// File: Bender.yml
package:
  name: vga_filter

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/vga_filter_pkg.sv
      - rtl/scan_if.sv
      - rtl/vga_timing.sv
      - rtl/window_addr.sv
      - rtl/image_memory.sv
      - rtl/pixel_filter.sv
      - rtl/vga_filter_top.sv
  - target: test
    include_dirs:
      - rtl
      - tests
    files:
      - tests/tb_clock.sv
      - tests/tb_vga_filter.sv
